/* design/pv2_isa_pkg.sv */
// PARCv2 instruction set definitions
// Field widths, opcode and funct codes, and the instruction word views

`default_nettype none

package pv2_isa_pkg;

  // Field widths
  localparam int unsigned word_w     = 32;
  localparam int unsigned reg_addr_w = 5;
  localparam int unsigned opcode_w   = 6;
  localparam int unsigned funct_w    = 6;
  localparam int unsigned imm_w      = 16;

  // --------------------
  // Primary opcodes
  localparam logic [opcode_w-1:0] op_rtype    = 6'h00;
  localparam logic [opcode_w-1:0] op_special2 = 6'h1c;
  localparam logic [opcode_w-1:0] op_addiu    = 6'h09;
  localparam logic [opcode_w-1:0] op_slti     = 6'h0a;
  localparam logic [opcode_w-1:0] op_sltiu    = 6'h0b;
  localparam logic [opcode_w-1:0] op_andi     = 6'h0c;
  localparam logic [opcode_w-1:0] op_ori      = 6'h0d;
  localparam logic [opcode_w-1:0] op_xori     = 6'h0e;
  localparam logic [opcode_w-1:0] op_lui      = 6'h0f;

  // --------------------
  // Funct codes, R-type unless noted
  localparam logic [funct_w-1:0] fn_sll  = 6'h00;
  localparam logic [funct_w-1:0] fn_srl  = 6'h02;
  localparam logic [funct_w-1:0] fn_sra  = 6'h03;
  localparam logic [funct_w-1:0] fn_addu = 6'h21;
  localparam logic [funct_w-1:0] fn_subu = 6'h23;
  localparam logic [funct_w-1:0] fn_and  = 6'h24;
  localparam logic [funct_w-1:0] fn_or   = 6'h25;
  localparam logic [funct_w-1:0] fn_xor  = 6'h26;
  localparam logic [funct_w-1:0] fn_nor  = 6'h27;
  localparam logic [funct_w-1:0] fn_slt  = 6'h2a;
  localparam logic [funct_w-1:0] fn_sltu = 6'h2b;
  // Special2 space
  localparam logic [funct_w-1:0] fn_mul  = 6'h02;

  // --------------------
  // Register form
  typedef struct packed {
    logic [opcode_w-1:0]   opcode;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] shamt;
    logic [funct_w-1:0]    funct;
  } pv2_rtype_t;

  // Immediate form
  typedef struct packed {
    logic [opcode_w-1:0]   opcode;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [imm_w-1:0]      imm;
  } pv2_itype_t;

  // Same word, two decodes
  typedef union packed {
    pv2_rtype_t rtype;
    pv2_itype_t itype;
  } pv2_inst_t;

endpackage

`default_nettype wire

/* design/pv2_exec_pkg.sv */
// Execute cluster definitions
// Datapath width, ALU function codes, result select and pipeline depth

`default_nettype none

package pv2_exec_pkg;

  // Operand width
  localparam int unsigned data_w = 32;

  // Multiplier split, also the lui half
  localparam int unsigned half_w = 16;

  // Acceptance to response, in cycles
  localparam int unsigned pipe_depth = 3;

  // --------------------
  // ALU function codes
  localparam int unsigned alu_fn_w = 4;

  localparam logic [alu_fn_w-1:0] alu_add  = 4'd0;
  localparam logic [alu_fn_w-1:0] alu_sub  = 4'd1;
  localparam logic [alu_fn_w-1:0] alu_and  = 4'd2;
  localparam logic [alu_fn_w-1:0] alu_or   = 4'd3;
  localparam logic [alu_fn_w-1:0] alu_xor  = 4'd4;
  localparam logic [alu_fn_w-1:0] alu_nor  = 4'd5;
  localparam logic [alu_fn_w-1:0] alu_slt  = 4'd6;
  localparam logic [alu_fn_w-1:0] alu_sltu = 4'd7;
  localparam logic [alu_fn_w-1:0] alu_sll  = 4'd8;
  localparam logic [alu_fn_w-1:0] alu_srl  = 4'd9;
  localparam logic [alu_fn_w-1:0] alu_sra  = 4'd10;
  localparam logic [alu_fn_w-1:0] alu_lui  = 4'd11;

  // --------------------
  // Which lane feeds the response
  localparam int unsigned sel_w = 2;

  localparam logic [sel_w-1:0] sel_alu     = 2'd0;
  localparam logic [sel_w-1:0] sel_mul     = 2'd1;
  localparam logic [sel_w-1:0] sel_illegal = 2'd2;

endpackage

`default_nettype wire

/* design/pv2_inst_decode.sv */
// Instruction decode for the execute cluster
// Picks operands, ALU function and result lane from one instruction word

`timescale 1ns/1ps
`default_nettype none

module pv2_inst_decode
  import pv2_isa_pkg::*, pv2_exec_pkg::*;
(
  input  pv2_inst_t           inst,
  input  logic [data_w-1:0]   rs_data,
  input  logic [data_w-1:0]   rt_data,
  output logic [data_w-1:0]   op_a,
  output logic [data_w-1:0]   op_b,
  output logic [alu_fn_w-1:0] alu_fn,
  output logic [sel_w-1:0]    res_sel
);

  // --------------------
  // Immediate forms
  logic [data_w-1:0] imm_sext;
  logic [data_w-1:0] imm_zext;
  logic [data_w-1:0] shamt_zext;

  assign imm_sext   = {{(data_w - imm_w){inst.itype.imm[imm_w-1]}}, inst.itype.imm};
  assign imm_zext   = {{(data_w - imm_w){1'b0}}, inst.itype.imm};
  // Shift amount rides in op_a
  assign shamt_zext = {{(data_w - reg_addr_w){1'b0}}, inst.rtype.shamt};

  // --------------------
  // Opcode, then funct
  always_comb begin
    // Register operands and add unless overridden
    op_a    = rs_data;
    op_b    = rt_data;
    alu_fn  = alu_add;
    res_sel = sel_alu;

    case (inst.rtype.opcode)
      op_rtype: begin
        case (inst.rtype.funct)
          fn_addu: alu_fn = alu_add;
          fn_subu: alu_fn = alu_sub;
          fn_and:  alu_fn = alu_and;
          fn_or:   alu_fn = alu_or;
          fn_xor:  alu_fn = alu_xor;
          fn_nor:  alu_fn = alu_nor;
          fn_slt:  alu_fn = alu_slt;
          fn_sltu: alu_fn = alu_sltu;
          // Shifts take rt as the value
          fn_sll: begin
            op_a   = shamt_zext;
            alu_fn = alu_sll;
          end
          fn_srl: begin
            op_a   = shamt_zext;
            alu_fn = alu_srl;
          end
          fn_sra: begin
            op_a   = shamt_zext;
            alu_fn = alu_sra;
          end
          default: res_sel = sel_illegal;
        endcase
      end
      // Only mul lives in special2 here
      op_special2: begin
        res_sel = (inst.rtype.funct == fn_mul) ? sel_mul : sel_illegal;
      end
      // Signed immediates
      op_addiu: op_b = imm_sext;
      op_slti: begin
        op_b   = imm_sext;
        alu_fn = alu_slt;
      end
      // Still sign extended, compare is unsigned
      op_sltiu: begin
        op_b   = imm_sext;
        alu_fn = alu_sltu;
      end
      // Logical immediates zero extend
      op_andi: begin
        op_b   = imm_zext;
        alu_fn = alu_and;
      end
      op_ori: begin
        op_b   = imm_zext;
        alu_fn = alu_or;
      end
      op_xori: begin
        op_b   = imm_zext;
        alu_fn = alu_xor;
      end
      op_lui: begin
        op_b   = imm_zext;
        alu_fn = alu_lui;
      end
      default: res_sel = sel_illegal;
    endcase
  end

endmodule

`default_nettype wire

/* design/pv2_alu_lane.sv */
// Two-stage ALU lane
// Operands captured in stage one, result computed and held in stage two

`timescale 1ns/1ps
`default_nettype none

module pv2_alu_lane
  import pv2_isa_pkg::*, pv2_exec_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                advance,
  input  logic [data_w-1:0]   op_a,
  input  logic [data_w-1:0]   op_b,
  input  logic [alu_fn_w-1:0] alu_fn,
  output logic [data_w-1:0]   alu_result
);

  // --------------------
  // Stage one
  logic [data_w-1:0]   a_q;
  logic [data_w-1:0]   b_q;
  logic [alu_fn_w-1:0] fn_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      fn_q <= alu_add;
    end else if (advance) begin
      a_q  <= op_a;
      b_q  <= op_b;
      fn_q <= alu_fn;
    end
  end

  // --------------------
  // Stage two compute
  logic [reg_addr_w-1:0] shamt;
  logic                  lt_s;
  logic                  lt_u;
  logic [data_w-1:0]     alu_out;

  // Only the low bits count for shifts
  assign shamt = a_q[reg_addr_w-1:0];
  assign lt_s  = $signed(a_q) < $signed(b_q);
  assign lt_u  = a_q < b_q;

  always_comb begin
    case (fn_q)
      alu_add:  alu_out = a_q + b_q;
      alu_sub:  alu_out = a_q - b_q;
      alu_and:  alu_out = a_q & b_q;
      alu_or:   alu_out = a_q | b_q;
      alu_xor:  alu_out = a_q ^ b_q;
      alu_nor:  alu_out = ~(a_q | b_q);
      alu_slt:  alu_out = {{(data_w - 1){1'b0}}, lt_s};
      alu_sltu: alu_out = {{(data_w - 1){1'b0}}, lt_u};
      // Shifted value comes from rt
      alu_sll:  alu_out = b_q << shamt;
      alu_srl:  alu_out = b_q >> shamt;
      alu_sra:  alu_out = $signed(b_q) >>> shamt;
      // Immediate to the upper half
      alu_lui:  alu_out = {b_q[half_w-1:0], {half_w{1'b0}}};
      default:  alu_out = '0;
    endcase
  end

  // Stage two register
  always_ff @(posedge clk) begin
    if (reset) begin
      alu_result <= '0;
    end else if (advance) begin
      alu_result <= alu_out;
    end
  end

endmodule

`default_nettype wire

/* design/pv2_mul_lane.sv */
// Two-stage multiply lane, low product word only
// Partial products in stage one, summed in stage two

`timescale 1ns/1ps
`default_nettype none

module pv2_mul_lane
  import pv2_exec_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              advance,
  input  logic [data_w-1:0] op_a,
  input  logic [data_w-1:0] op_b,
  output logic [data_w-1:0] mul_result
);

  // --------------------
  // Operand halves
  logic [half_w-1:0] a_lo;
  logic [half_w-1:0] a_hi;
  logic [half_w-1:0] b_lo;
  logic [half_w-1:0] b_hi;

  assign a_lo = op_a[half_w-1:0];
  assign a_hi = op_a[data_w-1:half_w];
  assign b_lo = op_b[half_w-1:0];
  assign b_hi = op_b[data_w-1:half_w];

  // Full low product, cross terms only need their low half
  // since they land shifted into the upper half
  logic [data_w-1:0] pp_ll;
  logic [half_w-1:0] pp_lh;
  logic [half_w-1:0] pp_hl;

  assign pp_ll = a_lo * b_lo;
  assign pp_lh = a_lo * b_hi;
  assign pp_hl = a_hi * b_lo;

  // --------------------
  // Stage one
  logic [data_w-1:0] ll_q;
  logic [half_w-1:0] lh_q;
  logic [half_w-1:0] hl_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      ll_q <= '0;
      lh_q <= '0;
      hl_q <= '0;
    end else if (advance) begin
      ll_q <= pp_ll;
      lh_q <= pp_lh;
      hl_q <= pp_hl;
    end
  end

  // --------------------
  // Stage two sum, wraps at data_w
  logic [half_w-1:0] cross_sum;
  logic [data_w-1:0] prod_lo;

  assign cross_sum = lh_q + hl_q;
  assign prod_lo   = ll_q + {cross_sum, {half_w{1'b0}}};

  always_ff @(posedge clk) begin
    if (reset) begin
      mul_result <= '0;
    end else if (advance) begin
      mul_result <= prod_lo;
    end
  end

endmodule

`default_nettype wire

/* design/pv2_result_merge.sv */
// Result merge and pipeline control
// Tracks valid and lane select, stalls all stages, registers the response

`timescale 1ns/1ps
`default_nettype none

module pv2_result_merge
  import pv2_exec_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              in_val,
  input  logic [sel_w-1:0]  res_sel,
  input  logic [data_w-1:0] alu_result,
  input  logic [data_w-1:0] mul_result,
  input  logic              resp_rdy,
  output logic              advance,
  output logic              resp_val,
  output logic [data_w-1:0] resp_data,
  output logic              resp_illegal
);

  // --------------------
  // Global stall
  // Only a response stuck at stage three stops the pipe
  assign advance = !(resp_val && !resp_rdy);

  // --------------------
  // Valid and select for stages one and two
  logic             val_s1;
  logic             val_s2;
  logic [sel_w-1:0] sel_s1;
  logic [sel_w-1:0] sel_s2;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_s1 <= 1'b0;
      val_s2 <= 1'b0;
      sel_s1 <= sel_alu;
      sel_s2 <= sel_alu;
    end else if (advance) begin
      // req_rdy is advance, so in_val here is an accepted request
      val_s1 <= in_val;
      sel_s1 <= res_sel;
      val_s2 <= val_s1;
      sel_s2 <= sel_s1;
    end
  end

  // --------------------
  // Lane pick
  logic [data_w-1:0] pick_data;
  logic              pick_illegal;

  always_comb begin
    pick_data    = '0;
    pick_illegal = 1'b0;
    case (sel_s2)
      sel_alu: pick_data = alu_result;
      sel_mul: pick_data = mul_result;
      // Unsupported word gives zero with the flag
      default: pick_illegal = 1'b1;
    endcase
  end

  // Stage three response register
  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val     <= 1'b0;
      resp_data    <= '0;
      resp_illegal <= 1'b0;
    end else if (advance) begin
      resp_val     <= val_s2;
      resp_data    <= pick_data;
      resp_illegal <= pick_illegal;
    end
  end

endmodule

`default_nettype wire

/* design/pv2_exec_cluster.sv */
// PARCv2 execute cluster
// Decode, ALU and multiply lanes side by side, merged into one response

`timescale 1ns/1ps
`default_nettype none

module pv2_exec_cluster
  import pv2_isa_pkg::*, pv2_exec_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  // Request
  input  logic              req_val,
  output logic              req_rdy,
  input  logic [word_w-1:0] req_inst,
  input  logic [data_w-1:0] req_rs_data,
  input  logic [data_w-1:0] req_rt_data,
  // Response
  output logic              resp_val,
  input  logic              resp_rdy,
  output logic [data_w-1:0] resp_data,
  output logic              resp_illegal
);

  // --------------------
  // Decode to lanes
  logic [data_w-1:0]   op_a;
  logic [data_w-1:0]   op_b;
  logic [alu_fn_w-1:0] alu_fn;
  logic [sel_w-1:0]    res_sel;

  // Lanes to merge
  logic [data_w-1:0] alu_result;
  logic [data_w-1:0] mul_result;

  // Global stall, low when the response is stuck
  logic advance;

  // Free slot in stage one whenever the pipe moves
  assign req_rdy = advance;

  pv2_inst_decode decode_inst (
    .inst    (req_inst),
    .rs_data (req_rs_data),
    .rt_data (req_rt_data),
    .op_a    (op_a),
    .op_b    (op_b),
    .alu_fn  (alu_fn),
    .res_sel (res_sel)
  );

  pv2_alu_lane alu_lane_inst (
    .clk        (clk),
    .reset      (reset),
    .advance    (advance),
    .op_a       (op_a),
    .op_b       (op_b),
    .alu_fn     (alu_fn),
    .alu_result (alu_result)
  );

  pv2_mul_lane mul_lane_inst (
    .clk        (clk),
    .reset      (reset),
    .advance    (advance),
    .op_a       (op_a),
    .op_b       (op_b),
    .mul_result (mul_result)
  );

  pv2_result_merge merge_inst (
    .clk          (clk),
    .reset        (reset),
    .in_val       (req_val),
    .res_sel      (res_sel),
    .alu_result   (alu_result),
    .mul_result   (mul_result),
    .resp_rdy     (resp_rdy),
    .advance      (advance),
    .resp_val     (resp_val),
    .resp_data    (resp_data),
    .resp_illegal (resp_illegal)
  );

endmodule

`default_nettype wire

/* tests/pv2_exec_vectors.svh */
// Stimulus table for the execute cluster testbench
// Each row has a name, an instruction word, rs and rt values, expected data and illegal flag

`ifndef PV2_EXEC_VECTORS_SVH
`define PV2_EXEC_VECTORS_SVH

typedef struct {
  string             name;
  pv2_inst_t         inst;
  logic [data_w-1:0] rs;
  logic [data_w-1:0] rt;
  logic [data_w-1:0] exp_data;
  logic              exp_illegal;
} vector_t;

vector_t vectors[$];

// Register form, fixed register numbers
function automatic pv2_inst_t encode_r(input logic [opcode_w-1:0] opcode,
                                       input logic [funct_w-1:0] funct,
                                       input logic [reg_addr_w-1:0] shamt);
  pv2_inst_t w;
  w.rtype.opcode = opcode;
  w.rtype.rs     = 5'd1;
  w.rtype.rt     = 5'd2;
  w.rtype.rd     = 5'd3;
  w.rtype.shamt  = shamt;
  w.rtype.funct  = funct;
  return w;
endfunction

// Immediate form
function automatic pv2_inst_t encode_i(input logic [opcode_w-1:0] opcode,
                                       input logic [imm_w-1:0] imm);
  pv2_inst_t w;
  w.itype.opcode = opcode;
  w.itype.rs     = 5'd1;
  w.itype.rt     = 5'd2;
  w.itype.imm    = imm;
  return w;
endfunction

function automatic void add_row(input string name, input pv2_inst_t inst,
                                input logic [data_w-1:0] rs, input logic [data_w-1:0] rt,
                                input logic [data_w-1:0] exp_data, input logic exp_illegal);
  vector_t v;
  v.name        = name;
  v.inst        = inst;
  v.rs          = rs;
  v.rt          = rt;
  v.exp_data    = exp_data;
  v.exp_illegal = exp_illegal;
  vectors.push_back(v);
endfunction

function automatic void load_vectors();
  // --------------------
  // R-type ALU
  add_row("addu", encode_r(op_rtype, fn_addu, 5'd0), 32'h5, 32'h7, 32'hc, 1'b0);
  add_row("addu_wrap", encode_r(op_rtype, fn_addu, 5'd0), 32'hffffffff, 32'h2, 32'h1, 1'b0);
  add_row("subu_neg", encode_r(op_rtype, fn_subu, 5'd0), 32'h5, 32'h7, 32'hfffffffe, 1'b0);
  add_row("and", encode_r(op_rtype, fn_and, 5'd0), 32'hf0f0ff00, 32'h0ff0f0f0, 32'h00f0f000, 1'b0);
  add_row("or", encode_r(op_rtype, fn_or, 5'd0), 32'hf0f0ff00, 32'h0ff0f0f0, 32'hfff0fff0, 1'b0);
  add_row("xor", encode_r(op_rtype, fn_xor, 5'd0), 32'hf0f0ff00, 32'h0ff0f0f0, 32'hff000ff0, 1'b0);
  add_row("nor", encode_r(op_rtype, fn_nor, 5'd0), 32'hf0f0ff00, 32'h0ff0f0f0, 32'h000f000f, 1'b0);
  // Negative rs, signed and unsigned disagree
  add_row("slt_neg", encode_r(op_rtype, fn_slt, 5'd0), 32'hfffffffe, 32'h1, 32'h1, 1'b0);
  add_row("sltu_neg", encode_r(op_rtype, fn_sltu, 5'd0), 32'hfffffffe, 32'h1, 32'h0, 1'b0);
  add_row("sltu_pos", encode_r(op_rtype, fn_sltu, 5'd0), 32'h1, 32'hfffffffe, 32'h1, 1'b0);
  // Shifts, rs value must not matter
  add_row("sll", encode_r(op_rtype, fn_sll, 5'd4), 32'hffffffff, 32'h800000f1, 32'h00000f10, 1'b0);
  add_row("srl", encode_r(op_rtype, fn_srl, 5'd4), 32'hffffffff, 32'h800000f1, 32'h0800000f, 1'b0);
  add_row("sra", encode_r(op_rtype, fn_sra, 5'd4), 32'hffffffff, 32'h800000f1, 32'hf800000f, 1'b0);
  // --------------------
  // Immediates
  add_row("addiu_neg", encode_i(op_addiu, 16'hfffc), 32'h10, 32'h0, 32'hc, 1'b0);
  add_row("slti_neg", encode_i(op_slti, 16'hffff), 32'h0, 32'h0, 32'h0, 1'b0);
  add_row("sltiu_neg", encode_i(op_sltiu, 16'hffff), 32'h00010000, 32'h0, 32'h1, 1'b0);
  add_row("andi", encode_i(op_andi, 16'hff00), 32'hffffffff, 32'h0, 32'h0000ff00, 1'b0);
  add_row("ori", encode_i(op_ori, 16'h8001), 32'h12340000, 32'h0, 32'h12348001, 1'b0);
  add_row("xori", encode_i(op_xori, 16'hffff), 32'haaaaaaaa, 32'h0, 32'haaaa5555, 1'b0);
  add_row("lui", encode_i(op_lui, 16'hbeef), 32'h12345678, 32'h0, 32'hbeef0000, 1'b0);
  // --------------------
  // Multiply, low word only
  add_row("mul", encode_r(op_special2, fn_mul, 5'd0), 32'h6, 32'h7, 32'h2a, 1'b0);
  add_row("mul_neg", encode_r(op_special2, fn_mul, 5'd0), 32'hfffffffd, 32'h5, 32'hfffffff1, 1'b0);
  add_row("mul_ovf", encode_r(op_special2, fn_mul, 5'd0), 32'h00010001, 32'h00010001,
          32'h00020001, 1'b0);
  add_row("mul_top", encode_r(op_special2, fn_mul, 5'd0), 32'h80000000, 32'h3, 32'h80000000, 1'b0);
  add_row("mul_m1", encode_r(op_special2, fn_mul, 5'd0), 32'hffffffff, 32'hffffffff, 32'h1, 1'b0);
  // --------------------
  // Unsupported words between valid ones
  add_row("ill_lw", encode_i(6'h23, 16'h0004), 32'h5, 32'h7, 32'h0, 1'b1);
  add_row("ill_jr", encode_r(op_rtype, 6'h08, 5'd0), 32'h5, 32'h7, 32'h0, 1'b1);
  add_row("ill_madd", encode_r(op_special2, 6'h00, 5'd0), 32'h5, 32'h7, 32'h0, 1'b1);
  add_row("addu_after", encode_r(op_rtype, fn_addu, 5'd0), 32'h100, 32'h23, 32'h123, 1'b0);
endfunction

`endif

/* tests/pv2_exec_cluster_tb.sv */
// Testbench for the execute cluster
// Table-driven requests, random back-pressure, in-order scoreboard and watchdog

`timescale 1ns/1ps
`default_nettype none

module pv2_exec_cluster_tb
  import pv2_isa_pkg::*, pv2_exec_pkg::*;
;

  localparam int num_passes     = 2;
  localparam int cycles_per_row = 20;
  localparam int reset_cycles   = 4;

  logic              clk;
  logic              reset;
  logic              req_val;
  logic              req_rdy;
  logic [word_w-1:0] req_inst;
  logic [data_w-1:0] req_rs_data;
  logic [data_w-1:0] req_rt_data;
  logic              resp_val;
  logic              resp_rdy;
  logic [data_w-1:0] resp_data;
  logic              resp_illegal;

  `include "pv2_exec_vectors.svh"

  // Row index and acceptance cycle per item in flight
  int                pending_rows[$];
  int                accept_cycles[$];
  int                cycle;
  int                sent;
  int                received;
  // Response held from the last sample
  bit                stalled;
  logic [data_w-1:0] held_data;
  logic              held_illegal;

  pv2_exec_cluster pv2_exec_cluster_inst (
    .clk          (clk),
    .reset        (reset),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .req_inst     (req_inst),
    .req_rs_data  (req_rs_data),
    .req_rt_data  (req_rt_data),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy),
    .resp_data    (resp_data),
    .resp_illegal (resp_illegal)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // --------------------
  // Sampled just after the falling edge with inputs settled
  task automatic check_response(input bit fixed_latency);
    int    row;
    int    waited;
    string name;
    if (stalled) begin
      assert (resp_val === 1'b1)
        else stop_on_error("resp_val dropped while the response was stalled");
      assert (resp_data === held_data && resp_illegal === held_illegal)
        else stop_on_error($sformatf("MISMATCH stall_hold expected %h/%b actual %h/%b",
                                     held_data, held_illegal, resp_data, resp_illegal));
    end
    if (resp_val && resp_rdy) begin
      assert (pending_rows.size() > 0)
        else stop_on_error("Response arrived with no request outstanding");
      row    = pending_rows.pop_front();
      waited = cycle - accept_cycles.pop_front();
      name   = vectors[row].name;
      assert (resp_data === vectors[row].exp_data)
        else stop_on_error($sformatf("MISMATCH %s data expected %h actual %h",
                                     name, vectors[row].exp_data, resp_data));
      assert (resp_illegal === vectors[row].exp_illegal)
        else stop_on_error($sformatf("MISMATCH %s illegal expected %b actual %b",
                                     name, vectors[row].exp_illegal, resp_illegal));
      // Full-rate pipe gives a fixed latency
      if (fixed_latency) begin
        assert (waited == pipe_depth)
          else stop_on_error($sformatf("MISMATCH %s latency expected %0d actual %0d",
                                       name, pipe_depth, waited));
      end
      received++;
    end
    stalled      = resp_val && !resp_rdy;
    held_data    = resp_data;
    held_illegal = resp_illegal;
  endtask

  // One pass over the table, then drain
  task automatic run_pass(input bit random_rdy);
    int idx;
    idx = 0;
    while (idx < vectors.size() || pending_rows.size() > 0) begin
      @(negedge clk);
      cycle++;
      if (idx < vectors.size()) begin
        req_val     = 1'b1;
        req_inst    = vectors[idx].inst;
        req_rs_data = vectors[idx].rs;
        req_rt_data = vectors[idx].rt;
      end else begin
        req_val     = 1'b0;
        req_inst    = '0;
        req_rs_data = '0;
        req_rt_data = '0;
      end
      resp_rdy = random_rdy ? 1'($urandom % 2) : 1'b1;
      #1;
      check_response(!random_rdy);
      // Nothing stalls the pipe at full rate
      if (!random_rdy && idx < vectors.size()) begin
        assert (req_rdy === 1'b1)
          else stop_on_error("req_rdy went low while resp_rdy was held high");
      end
      // Handshake completes on the coming rising edge
      if (req_val && req_rdy) begin
        pending_rows.push_back(idx);
        accept_cycles.push_back(cycle);
        idx++;
        sent++;
      end
    end
  endtask

  // --------------------
  // Watchdog
  initial begin
    wait (vectors.size() > 0);
    repeat (vectors.size() * num_passes * cycles_per_row + reset_cycles) @(posedge clk);
    stop_on_error("Timeout: the test did not finish in the allowed number of cycles");
  end

  initial begin
    void'($urandom(33223));
    req_val     = 1'b0;
    req_inst    = '0;
    req_rs_data = '0;
    req_rt_data = '0;
    resp_rdy    = 1'b0;
    reset       = 1'b1;
    cycle       = 0;
    sent        = 0;
    received    = 0;
    stalled     = 1'b0;
    load_vectors();
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    #1;
    assert (resp_val === 1'b0 && req_rdy === 1'b1)
      else stop_on_error("After reset resp_val is not low or req_rdy is not high");
    // Back to back with resp_rdy held high, then random back-pressure
    run_pass(1'b0);
    run_pass(1'b1);
    // Idle cycles catch repeated responses
    repeat (4) begin
      @(negedge clk);
      cycle++;
      req_val  = 1'b0;
      resp_rdy = 1'b1;
      #1;
      check_response(1'b0);
    end
    assert (sent == vectors.size() * num_passes && received == sent)
      else stop_on_error($sformatf("MISMATCH response_count expected %0d actual %0d",
                                   vectors.size() * num_passes, received));
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+tests
design/pv2_isa_pkg.sv
design/pv2_exec_pkg.sv
design/pv2_inst_decode.sv
design/pv2_alu_lane.sv
design/pv2_mul_lane.sv
design/pv2_result_merge.sv
design/pv2_exec_cluster.sv
tests/pv2_exec_cluster_tb.sv

/* Bender.yml */
package:
  name: pv2_exec_cluster

sources:
  - design/pv2_isa_pkg.sv
  - design/pv2_exec_pkg.sv
  - design/pv2_inst_decode.sv
  - design/pv2_alu_lane.sv
  - design/pv2_mul_lane.sv
  - design/pv2_result_merge.sv
  - design/pv2_exec_cluster.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/pv2_exec_cluster_tb.sv
